//--- src/decode_pkg.sv
// Decode package with widths, opcode values, operation and select enums, micro-op struct
package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [6:0] F7_BASE = 7'b0000000; // Plain ALU and shift funct7
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA and SRAI

    // Register and immediate forms share one op and differ in opd_sel
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JAL,
        OP_JALR,
        OP_LUI,
        OP_AUIPC
    } op_e;

    typedef enum logic [1:0] {
        OPD_REG    = 2'b00, // rs1, rs2
        OPD_IMM    = 2'b01, // rs1, imm
        OPD_PC     = 2'b10, // pc, rs2
        OPD_PC_IMM = 2'b11  // pc, imm
    } opd_sel_e;

    // Code 2'b11 is unused and acts as FWD_NONE
    typedef enum logic [1:0] {
        FWD_NONE      = 2'b00,
        FWD_EXECUTE   = 2'b01,
        FWD_WRITEBACK = 2'b10
    } fwd_sel_e;

    typedef struct packed {
        op_e      op;
        opd_sel_e opd_sel;
        logic     rd_write;
        logic     mem_read;
        logic     mem_write;
    } micro_op_t;

    localparam micro_op_t NOP_UOP = '{
        op:        OP_NOP,
        opd_sel:   OPD_REG,
        rd_write:  1'b0,
        mem_read:  1'b0,
        mem_write: 1'b0
    };

endpackage

//--- src/reg_read_if.sv
// Register read port bundle between the register file and the operand unit
`timescale 1ns/1ps

interface reg_read_if;

    logic [decode_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [decode_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [decode_pkg::XLEN-1:0]       rs1_data;
    logic [decode_pkg::XLEN-1:0]       rs2_data;

    modport provider (
        input  rs1_addr, rs2_addr,
        output rs1_data, rs2_data
    );

    modport consumer (
        input rs1_data, rs2_data
    );

endinterface

//--- src/instr_decoder.sv
// RV32I instruction decoder producing the micro-op and the sign-extended immediate
`timescale 1ns/1ps

module instr_decoder import decode_pkg::*; (
    input  logic [XLEN-1:0] instr_i,
    output micro_op_t       uop_o,
    output logic [XLEN-1:0] imm_o
);

    typedef enum logic [2:0] {FMT_I, FMT_S, FMT_B, FMT_J, FMT_U} imm_fmt_e;

    logic [6:0]  opcode;
    logic [16:0] key;      // funct7, funct3, opcode
    op_e         op;
    imm_fmt_e    fmt;
    opd_sel_e    opd_sel;
    logic        rd_write;
    logic        mem_read;
    logic        mem_write;

    assign opcode = instr_i[6:0];
    assign key    = {instr_i[31:25], instr_i[14:12], opcode};

    // Most specific patterns first
    always_comb begin
        casez (key)
            {F7_BASE, 3'b000, OPC_OP}:        op = OP_ADD;
            {F7_ALT,  3'b000, OPC_OP}:        op = OP_SUB;
            {F7_BASE, 3'b001, OPC_OP}:        op = OP_SLL;
            {F7_BASE, 3'b010, OPC_OP}:        op = OP_SLT;
            {F7_BASE, 3'b011, OPC_OP}:        op = OP_SLTU;
            {F7_BASE, 3'b100, OPC_OP}:        op = OP_XOR;
            {F7_BASE, 3'b101, OPC_OP}:        op = OP_SRL;
            {F7_ALT,  3'b101, OPC_OP}:        op = OP_SRA;
            {F7_BASE, 3'b110, OPC_OP}:        op = OP_OR;
            {F7_BASE, 3'b111, OPC_OP}:        op = OP_AND;
            {F7_BASE, 3'b001, OPC_OP_IMM}:    op = OP_SLL;  // SLLI
            {F7_BASE, 3'b101, OPC_OP_IMM}:    op = OP_SRL;  // SRLI
            {F7_ALT,  3'b101, OPC_OP_IMM}:    op = OP_SRA;  // SRAI
            {7'b???????, 3'b000, OPC_OP_IMM}: op = OP_ADD;
            {7'b???????, 3'b010, OPC_OP_IMM}: op = OP_SLT;
            {7'b???????, 3'b011, OPC_OP_IMM}: op = OP_SLTU;
            {7'b???????, 3'b100, OPC_OP_IMM}: op = OP_XOR;
            {7'b???????, 3'b110, OPC_OP_IMM}: op = OP_OR;
            {7'b???????, 3'b111, OPC_OP_IMM}: op = OP_AND;
            {7'b???????, 3'b000, OPC_LOAD}:   op = OP_LB;
            {7'b???????, 3'b001, OPC_LOAD}:   op = OP_LH;
            {7'b???????, 3'b010, OPC_LOAD}:   op = OP_LW;
            {7'b???????, 3'b100, OPC_LOAD}:   op = OP_LBU;
            {7'b???????, 3'b101, OPC_LOAD}:   op = OP_LHU;
            {7'b???????, 3'b000, OPC_STORE}:  op = OP_SB;
            {7'b???????, 3'b001, OPC_STORE}:  op = OP_SH;
            {7'b???????, 3'b010, OPC_STORE}:  op = OP_SW;
            {7'b???????, 3'b000, OPC_BRANCH}: op = OP_BEQ;
            {7'b???????, 3'b001, OPC_BRANCH}: op = OP_BNE;
            {7'b???????, 3'b100, OPC_BRANCH}: op = OP_BLT;
            {7'b???????, 3'b101, OPC_BRANCH}: op = OP_BGE;
            {7'b???????, 3'b110, OPC_BRANCH}: op = OP_BLTU;
            {7'b???????, 3'b111, OPC_BRANCH}: op = OP_BGEU;
            {7'b???????, 3'b000, OPC_JALR}:   op = OP_JALR;
            {7'b???????, 3'b???, OPC_JAL}:    op = OP_JAL;
            {7'b???????, 3'b???, OPC_LUI}:    op = OP_LUI;
            {7'b???????, 3'b???, OPC_AUIPC}:  op = OP_AUIPC;
            default:                          op = OP_NOP; // Unknown word
        endcase
    end

    // Format, operand source and side flags follow the opcode
    always_comb begin
        fmt       = FMT_I;
        opd_sel   = OPD_IMM;
        rd_write  = 1'b1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        case (opcode)
            OPC_OP:     opd_sel = OPD_REG;
            OPC_LOAD:   mem_read = 1'b1;
            OPC_STORE: begin
                fmt       = FMT_S;
                rd_write  = 1'b0;
                mem_write = 1'b1;
            end
            OPC_BRANCH: begin
                fmt      = FMT_B;
                opd_sel  = OPD_PC_IMM; // Target is pc + imm
                rd_write = 1'b0;
            end
            OPC_JAL: begin
                fmt     = FMT_J;
                opd_sel = OPD_PC_IMM;
            end
            OPC_LUI:    fmt = FMT_U;
            OPC_AUIPC: begin
                fmt     = FMT_U;
                opd_sel = OPD_PC_IMM;
            end
            default: ;  // OP_IMM, JALR and unknown keep I format
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_S:   imm_o = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            FMT_B:   imm_o = {{(XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                              instr_i[11:8], 1'b0};
            FMT_J:   imm_o = {{(XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                              instr_i[30:21], 1'b0};
            FMT_U:   imm_o = {instr_i[31:12], 12'b0};
            default: imm_o = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
        endcase
    end

    assign uop_o = (op == OP_NOP) ? NOP_UOP :
                   '{op: op, opd_sel: opd_sel, rd_write: rd_write,
                     mem_read: mem_read, mem_write: mem_write};

endmodule

//--- src/register_file.sv
// 32-entry integer register file, two combinational reads and one write port
`timescale 1ns/1ps

module register_file import decode_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic [REG_ADDR_W-1:0] wb_addr_i,
    input  logic [XLEN-1:0]       wb_data_i,
    input  logic                  wb_write_i,
    reg_read_if.provider          rd
);

    logic [XLEN-1:0] regs [1:NUM_REGS-1]; // x0 has no storage

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write_i && (wb_addr_i != '0)) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    // A read during a same-cycle write returns the old value
    always_comb begin
        if (rd.rs1_addr == '0) begin
            rd.rs1_data = '0;
        end else begin
            rd.rs1_data = regs[rd.rs1_addr];
        end
        if (rd.rs2_addr == '0) begin
            rd.rs2_data = '0;
        end else begin
            rd.rs2_data = regs[rd.rs2_addr];
        end
    end

endmodule

//--- src/operand_forward.sv
// Operand forwarding, branch compare flags and PC or immediate operand selection
`timescale 1ns/1ps

module operand_forward import decode_pkg::*; (
    reg_read_if.consumer    rd,
    input  fwd_sel_e        fwd_sel1_i,
    input  fwd_sel_e        fwd_sel2_i,
    input  logic [XLEN-1:0] ex_fwd_data_i,
    input  logic [XLEN-1:0] wb_data_i,
    input  opd_sel_e        opd_sel_i,
    input  logic [XLEN-1:1] pc_i,
    input  logic [XLEN-1:0] imm_i,
    output logic [XLEN-1:0] op1_o,
    output logic [XLEN-1:0] op2_o,
    output logic [2:0]      cmp_o
);

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic            use_pc;
    logic            use_imm;

    function automatic logic [XLEN-1:0] fwd_mux(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] reg_val,
        input logic [XLEN-1:0] ex_val,
        input logic [XLEN-1:0] wb_val
    );
        case (sel)
            FWD_EXECUTE:   fwd_mux = ex_val;
            FWD_WRITEBACK: fwd_mux = wb_val;
            default:       fwd_mux = reg_val; // FWD_NONE and spare code
        endcase
    endfunction

    assign src1 = fwd_mux(fwd_sel1_i, rd.rs1_data, ex_fwd_data_i, wb_data_i);
    assign src2 = fwd_mux(fwd_sel2_i, rd.rs2_data, ex_fwd_data_i, wb_data_i);

    // Flags use the register values before PC or imm replace them
    assign cmp_o = {$signed(src1) < $signed(src2), src1 < src2, src1 == src2};

    assign use_pc  = (opd_sel_i == OPD_PC)  || (opd_sel_i == OPD_PC_IMM);
    assign use_imm = (opd_sel_i == OPD_IMM) || (opd_sel_i == OPD_PC_IMM);

    assign op1_o = use_pc  ? {pc_i, 1'b0} : src1;
    assign op2_o = use_imm ? imm_i        : src2;

endmodule

//--- src/decode_stage.sv
// Decode and register-read stage top level with the ID/EX pipeline register
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // From fetch
    input  logic [XLEN-1:0]       instr_i,
    input  logic [XLEN-1:1]       pc_i,
    input  logic [XLEN-1:1]       pc_next_i,     // Link value for JAL and JALR

    // Forwarded results
    input  logic [XLEN-1:0]       ex_fwd_data_i,
    input  logic [REG_ADDR_W-1:0] wb_addr_i,
    input  logic [XLEN-1:0]       wb_data_i,
    input  logic                  wb_write_i,

    // Hazard unit
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  fwd_sel_e              fwd_sel1_i,
    input  fwd_sel_e              fwd_sel2_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,

    // To execute
    output micro_op_t             ex_uop_o,
    output logic [XLEN-1:0]       ex_op1_o,
    output logic [XLEN-1:0]       ex_op2_o,
    output logic [2:0]            ex_cmp_o,      // {lt, ltu, eq}
    output logic [XLEN-1:1]       ex_pc_next_o,
    output logic [REG_ADDR_W-1:0] ex_rd_addr_o
);

    micro_op_t       uop;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [2:0]      cmp;

    reg_read_if rr ();

    assign rr.rs1_addr = instr_i[19:15];
    assign rr.rs2_addr = instr_i[24:20];
    assign rs1_addr_o  = rr.rs1_addr;
    assign rs2_addr_o  = rr.rs2_addr;

    instr_decoder i_decoder (
        .instr_i (instr_i),
        .uop_o   (uop),
        .imm_o   (imm)
    );

    register_file i_regfile (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i),
        .wb_write_i (wb_write_i),
        .rd         (rr.provider)
    );

    operand_forward i_operands (
        .rd            (rr.consumer),
        .fwd_sel1_i    (fwd_sel1_i),
        .fwd_sel2_i    (fwd_sel2_i),
        .ex_fwd_data_i (ex_fwd_data_i),
        .wb_data_i     (wb_data_i),
        .opd_sel_i     (uop.opd_sel),
        .pc_i          (pc_i),
        .imm_i         (imm),
        .op1_o         (op1),
        .op2_o         (op2),
        .cmp_o         (cmp)
    );

    // Control part where stall wins over flush
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_uop_o <= NOP_UOP;
            ex_cmp_o <= '0;
        end else if (!stall_i) begin
            ex_uop_o <= flush_i ? NOP_UOP : uop; // Bubble on flush
            ex_cmp_o <= cmp;
        end
    end

    // Payload part
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            ex_op1_o     <= op1;
            ex_op2_o     <= op2;
            ex_pc_next_o <= pc_next_i;
            ex_rd_addr_o <= instr_i[11:7];
        end
    end

endmodule

//--- verification/decode_vectors.svh
// Decode stage vector table built from the random register and forwarding values
task automatic build_vectors();
    logic [XLEN-1:0] v1;
    logic [XLEN-1:0] v2;
    logic [XLEN-1:0] v3;
    logic [XLEN-1:0] v4;
    logic [XLEN-1:0] fe;
    logic [XLEN-1:0] fw;
    v1 = reg_val[1];
    v2 = reg_val[2];
    v3 = reg_val[3];
    v4 = reg_val[4];
    fe = ex_fwd_val;
    fw = wb_fwd_val;

    // add x5, x6, x7 on freshly reset registers
    add_instr(32'h007302B3, make_uop(OP_ADD, OPD_REG, 1, 0, 0), 32'h0, 32'h0, 3'b001);
    add_write(5'd1, v1);
    add_write(5'd2, v2);
    add_write(5'd3, v3);
    add_write(5'd4, v4);
    add_write(5'd0, v4);                                     // x0 keeps zero

    add_instr(32'h002082B3, make_uop(OP_ADD, OPD_REG, 1, 0, 0), v1, v2, compare_flags(v1, v2));
    add_instr(32'h40418333, make_uop(OP_SUB, OPD_REG, 1, 0, 0), v3, v4, compare_flags(v3, v4));
    add_instr(32'h001123B3, make_uop(OP_SLT, OPD_REG, 1, 0, 0), v2, v1, compare_flags(v2, v1));
    add_instr(32'h00108433, make_uop(OP_ADD, OPD_REG, 1, 0, 0), v1, v1, compare_flags(v1, v1));
    add_instr(32'h001004B3, make_uop(OP_ADD, OPD_REG, 1, 0, 0), 32'h0, v1,
              compare_flags(32'h0, v1));                     // add x9, x0, x1

    // Immediate formats with rs2 fields of unused registers reading zero
    add_instr(32'hFFB08513, make_uop(OP_ADD, OPD_IMM, 1, 0, 0), v1, 32'hFFFFFFFB,
              compare_flags(v1, 32'h0));                     // addi x10, x1, -5
    add_instr(32'h00812583, make_uop(OP_LW, OPD_IMM, 1, 1, 0), v2, 32'h8,
              compare_flags(v2, 32'h0));                     // lw x11, 8(x2)
    add_instr(32'h0020A623, make_uop(OP_SW, OPD_IMM, 0, 0, 1), v1, 32'hC,
              compare_flags(v1, v2));                        // sw x2, 12(x1)
    add_instr(32'hFE2088E3, make_uop(OP_BEQ, OPD_PC_IMM, 0, 0, 0), entry_pc(), 32'hFFFFFFF0,
              compare_flags(v1, v2));                        // beq x1, x2, -16
    add_instr(32'hFFDFF0EF, make_uop(OP_JAL, OPD_PC_IMM, 1, 0, 0), entry_pc(), 32'hFFFFFFFC,
              3'b001);                                       // jal x1, -4
    add_instr(32'hABCDE637, make_uop(OP_LUI, OPD_IMM, 1, 0, 0), 32'h0, 32'hABCDE000, 3'b001);
    add_instr(32'h12345697, make_uop(OP_AUIPC, OPD_PC_IMM, 1, 0, 0), entry_pc(), 32'h12345000,
              compare_flags(32'h0, v3));                     // auipc x13, 0x12345

    // Forwarding followed by a stalled entry that must hold it
    add_instr(32'h002082B3, make_uop(OP_ADD, OPD_REG, 1, 0, 0), fe, fw, compare_flags(fe, fw));
    set_forwarding(FWD_EXECUTE, FWD_WRITEBACK, fe, fw);
    add_stall(32'h40418333);
    add_instr(32'hFE2088E3, make_uop(OP_BEQ, OPD_PC_IMM, 0, 0, 0), entry_pc(), 32'hFFFFFFF0,
              3'b001);                                       // Forwarded rs1 equals rs2
    set_forwarding(FWD_EXECUTE, FWD_NONE, v2, 32'h0);

    // Write-back to x4 in the same cycle as its read
    add_instr(32'h40418333, make_uop(OP_SUB, OPD_REG, 1, 0, 0), v3, fw, compare_flags(v3, fw));
    set_forwarding(FWD_NONE, FWD_WRITEBACK, 32'h0, fw);
    vectors[$].wb_addr  = 5'd4;
    vectors[$].wb_write = 1'b1;
    add_instr(32'h40418333, make_uop(OP_SUB, OPD_REG, 1, 0, 0), v3, fw, compare_flags(v3, fw));

    add_instr(32'h001123B3, NOP_UOP, v2, v1, compare_flags(v2, v1)); // slt x7, x2, x1
    vectors[$].flush = 1'b1;                                 // Bubble while the payload moves
    add_instr(32'h0000000B, NOP_UOP, 32'h0, 32'h0, 3'b001);  // custom-0 word
endtask

//--- verification/tb_decode_stage.sv
// Testbench for the decode stage with clock, reset, watchdog and table-driven checks
`timescale 1ns/1ps

module tb_decode_stage import decode_pkg::*; ();

    localparam int CLK_PERIOD = 100; // ns

    typedef struct {
        logic [XLEN-1:0]       instr;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pc_next;
        fwd_sel_e              fwd1;
        fwd_sel_e              fwd2;
        logic [XLEN-1:0]       ex_val;
        logic [XLEN-1:0]       wb_val;
        logic [REG_ADDR_W-1:0] wb_addr;
        logic                  wb_write;
        logic                  stall;
        logic                  flush;
        logic                  check;
        micro_op_t             exp_uop;
        logic [XLEN-1:0]       exp_op1;
        logic [XLEN-1:0]       exp_op2;
        logic [2:0]            exp_cmp;
        logic [XLEN-1:0]       exp_pc_next;
        logic [REG_ADDR_W-1:0] exp_rd;
    } vector_t;

    logic                  clk_i;
    logic                  rst_i;
    logic [XLEN-1:0]       instr_i;
    logic [XLEN-1:1]       pc_i;
    logic [XLEN-1:1]       pc_next_i;
    logic [XLEN-1:0]       ex_fwd_data_i;
    logic [REG_ADDR_W-1:0] wb_addr_i;
    logic [XLEN-1:0]       wb_data_i;
    logic                  wb_write_i;
    logic                  stall_i;
    logic                  flush_i;
    fwd_sel_e              fwd_sel1_i;
    fwd_sel_e              fwd_sel2_i;
    logic [REG_ADDR_W-1:0] rs1_addr_o;
    logic [REG_ADDR_W-1:0] rs2_addr_o;
    micro_op_t             ex_uop_o;
    logic [XLEN-1:0]       ex_op1_o;
    logic [XLEN-1:0]       ex_op2_o;
    logic [2:0]            ex_cmp_o;
    logic [XLEN-1:1]       ex_pc_next_o;
    logic [REG_ADDR_W-1:0] ex_rd_addr_o;

    vector_t         vectors [$];
    int              seed;
    logic [XLEN-1:0] reg_val [1:4]; // Values written to x1 to x4
    logic [XLEN-1:0] ex_fwd_val;
    logic [XLEN-1:0] wb_fwd_val;

    decode_stage i_dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .pc_next_i     (pc_next_i),
        .ex_fwd_data_i (ex_fwd_data_i),
        .wb_addr_i     (wb_addr_i),
        .wb_data_i     (wb_data_i),
        .wb_write_i    (wb_write_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .fwd_sel1_i    (fwd_sel1_i),
        .fwd_sel2_i    (fwd_sel2_i),
        .rs1_addr_o    (rs1_addr_o),
        .rs2_addr_o    (rs2_addr_o),
        .ex_uop_o      (ex_uop_o),
        .ex_op1_o      (ex_op1_o),
        .ex_op2_o      (ex_op2_o),
        .ex_cmp_o      (ex_cmp_o),
        .ex_pc_next_o  (ex_pc_next_o),
        .ex_rd_addr_o  (ex_rd_addr_o)
    );

    // Branch flags {lt, ltu, eq} from a subtraction and the sign bits
    function automatic logic [2:0] compare_flags(input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
        logic [XLEN:0] diff;
        logic          lt;
        diff = {1'b0, a} - {1'b0, b}; // Borrow lands in the top bit
        if (a[XLEN-1] != b[XLEN-1]) begin
            lt = a[XLEN-1]; // Negative a is the smaller one
        end else begin
            lt = diff[XLEN];
        end
        return {lt, diff[XLEN], diff[XLEN-1:0] == '0};
    endfunction

    function automatic micro_op_t make_uop(input op_e op, input opd_sel_e sel,
                                           input logic wr, input logic mr, input logic mw);
        return '{op, sel, wr, mr, mw};
    endfunction

    function automatic logic [XLEN-1:0] entry_pc();
        return 32'h0000_1000 + 32'(4 * vectors.size()); // Word-aligned PC per entry
    endfunction

    function automatic vector_t blank_vector(input logic [XLEN-1:0] instr);
        vector_t v;
        v.instr       = instr;
        v.pc          = entry_pc();
        v.pc_next     = v.pc + 32'd4;
        v.fwd1        = FWD_NONE;
        v.fwd2        = FWD_NONE;
        v.ex_val      = '0;
        v.wb_val      = '0;
        v.wb_addr     = '0;
        v.wb_write    = 1'b0;
        v.stall       = 1'b0;
        v.flush       = 1'b0;
        v.check       = 1'b0;
        v.exp_uop     = NOP_UOP;
        v.exp_op1     = '0;
        v.exp_op2     = '0;
        v.exp_cmp     = '0;
        v.exp_pc_next = v.pc_next;
        v.exp_rd      = instr[11:7]; // rd field
        return v;
    endfunction

    function automatic void add_write(input logic [REG_ADDR_W-1:0] addr,
                                      input logic [XLEN-1:0] data);
        vector_t v;
        v          = blank_vector('0);
        v.wb_addr  = addr;
        v.wb_val   = data;
        v.wb_write = 1'b1;
        vectors.push_back(v);
    endfunction

    function automatic void add_instr(input logic [XLEN-1:0] instr, input micro_op_t uop,
                                      input logic [XLEN-1:0] op1, input logic [XLEN-1:0] op2,
                                      input logic [2:0] cmp);
        vector_t v;
        v         = blank_vector(instr);
        v.check   = 1'b1;
        v.exp_uop = uop;
        v.exp_op1 = op1;
        v.exp_op2 = op2;
        v.exp_cmp = cmp;
        vectors.push_back(v);
    endfunction

    // Outputs hold during a stall, so the previous expected fields carry over
    function automatic void add_stall(input logic [XLEN-1:0] instr);
        vector_t v;
        v          = vectors[$];
        v.instr    = instr;
        v.pc       = entry_pc();
        v.pc_next  = v.pc + 32'd4;
        v.fwd1     = FWD_NONE;
        v.fwd2     = FWD_NONE;
        v.wb_write = 1'b0;
        v.flush    = 1'b0;
        v.stall    = 1'b1;
        vectors.push_back(v);
    endfunction

    function automatic void set_forwarding(input fwd_sel_e sel1, input fwd_sel_e sel2,
                                           input logic [XLEN-1:0] ex_val,
                                           input logic [XLEN-1:0] wb_val);
        vectors[$].fwd1   = sel1;
        vectors[$].fwd2   = sel2;
        vectors[$].ex_val = ex_val;
        vectors[$].wb_val = wb_val;
    endfunction

    `include "decode_vectors.svh"

    task automatic apply_vector(input vector_t v);
        instr_i       = v.instr;
        pc_i          = v.pc[XLEN-1:1];
        pc_next_i     = v.pc_next[XLEN-1:1];
        fwd_sel1_i    = v.fwd1;
        fwd_sel2_i    = v.fwd2;
        ex_fwd_data_i = v.ex_val;
        wb_data_i     = v.wb_val;
        wb_addr_i     = v.wb_addr;
        wb_write_i    = v.wb_write;
        stall_i       = v.stall;
        flush_i       = v.flush;
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic check_outputs(input vector_t v, input int idx);
        check_value($sformatf("entry %0d rs1_addr_o", idx), rs1_addr_o, v.instr[19:15]);
        check_value($sformatf("entry %0d rs2_addr_o", idx), rs2_addr_o, v.instr[24:20]);
        check_value($sformatf("entry %0d ex_uop_o", idx), ex_uop_o, v.exp_uop);
        check_value($sformatf("entry %0d ex_op1_o", idx), ex_op1_o, v.exp_op1);
        check_value($sformatf("entry %0d ex_op2_o", idx), ex_op2_o, v.exp_op2);
        check_value($sformatf("entry %0d ex_cmp_o", idx), ex_cmp_o, v.exp_cmp);
        check_value($sformatf("entry %0d ex_pc_next_o", idx), ex_pc_next_o,
                    v.exp_pc_next[XLEN-1:1]);
        check_value($sformatf("entry %0d ex_rd_addr_o", idx), ex_rd_addr_o, v.exp_rd);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Run length follows the table size
    initial begin
        #1;
        #((vectors.size() + 20) * CLK_PERIOD);
        $display("Simulation timed out before all table entries were checked");
        $display("test failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        rst_i = 1'b1;
        apply_vector(blank_vector(32'h002082B3)); // Live ADD while in reset
        seed = 67;
        for (int k = 1; k <= 4; k++) begin
            reg_val[k] = $random(seed);
        end
        ex_fwd_val = $random(seed);
        wb_fwd_val = $random(seed);
        build_vectors();

        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        check_value("reset ex_uop_o", ex_uop_o, NOP_UOP);
        check_value("reset ex_cmp_o", ex_cmp_o, 3'b000);

        for (int i = 0; i < vectors.size(); i++) begin
            apply_vector(vectors[i]); // 1 ns after the edge
            @(posedge clk_i);
            #1;
            if (vectors[i].check) begin
                check_outputs(vectors[i], i);
            end
        end

        $display("test passed");
        $finish;
    end

endmodule

//--- decode_stage.f
+incdir+verification
src/decode_pkg.sv
src/reg_read_if.sv
src/instr_decoder.sv
src/register_file.sv
src/operand_forward.sv
src/decode_stage.sv
verification/tb_decode_stage.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - src/decode_pkg.sv
  - src/reg_read_if.sv
  - src/instr_decoder.sv
  - src/register_file.sv
  - src/operand_forward.sv
  - src/decode_stage.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_decode_stage.sv
